//--- rtl/core_pkg.sv
// ------------------------------------------------
// RV32 core shared definitions
// ------------------------------------------------

package core_pkg;

    // ------------------------------------------------
    // Widths and boot address
    // ------------------------------------------------
    localparam int unsigned XLEN = 32;
    localparam int unsigned ILEN = 32;

    localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0000;

    // ------------------------------------------------
    // Opcodes and function fields
    // ------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [6:0] F7_ADD  = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ------------------------------------------------
    // Instruction word, two views
    // ------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // ------------------------------------------------
    // Internal request and answer
    // ------------------------------------------------
    typedef struct packed {
        logic            valid;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } mem_ans_t;

    // Frontend to backend
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_u          instr;
    } fetch_t;

    // Branch or jump outcome
    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [XLEN-1:0] target;
    } resolution_t;

    // ------------------------------------------------
    // Wishbone classic
    // ------------------------------------------------
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
        logic [3:0]      sel;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

endpackage

//--- rtl/main_cu.sv
// ------------------------------------------------
// Main control unit
// ------------------------------------------------
`timescale 1ns/1ps

module main_cu (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  core_pkg::resolution_t res_i,
    input  logic                  ecall_i,
    input  logic                  except_i,
    output logic                  flush_o,
    output logic                  stall_o,
    output logic                  halt_o,
    output logic                  except_o
);

    typedef enum logic {
        CU_RUN,
        CU_HALTED
    } cu_state_e;

    cu_state_e state_q;
    cu_state_e state_d;
    logic      flush_q;
    logic      except_q;

    // Halted is terminal until reset
    always_comb begin
        state_d = state_q;
        if (state_q == CU_RUN && (ecall_i || except_i)) begin
            state_d = CU_HALTED;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= CU_RUN;
            flush_q  <= 1'b0;
            except_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // One-cycle flush after a taken resolution
            flush_q <= (state_q == CU_RUN) & res_i.valid & res_i.taken;
            if (state_q == CU_RUN && except_i) begin
                except_q <= 1'b1;
            end
        end
    end

    // Hold the pipe during the flush cycle too, so no wrong-path word is taken
    assign flush_o  = flush_q;
    assign stall_o  = (state_q == CU_HALTED) | flush_q;
    assign halt_o   = (state_q == CU_HALTED);
    assign except_o = except_q;

endmodule

//--- rtl/frontend.sv
// ------------------------------------------------
// Instruction fetch frontend
// ------------------------------------------------
`timescale 1ns/1ps

module frontend (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  stall_i,
    input  core_pkg::resolution_t res_i,
    output core_pkg::mem_req_t    mem_req_o,
    input  core_pkg::mem_ans_t    mem_ans_i,
    output core_pkg::fetch_t      fetch_o,
    input  logic                  fetch_ready_i
);

    import core_pkg::*;

    // Fetch state
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] redirect_q;
    logic            busy_q;
    logic            discard_q;

    // One-entry instruction buffer
    logic            buf_valid_q;
    logic [XLEN-1:0] buf_pc_q;
    instr_u          buf_instr_q;

    logic            take;
    logic            start;
    logic            fill;

    assign take  = buf_valid_q & fetch_ready_i;
    // New fetch only when the buffer is free or being emptied
    assign start = ~busy_q & (~buf_valid_q | take) & ~stall_i & ~flush_i;
    assign fill  = busy_q & mem_ans_i.valid & ~discard_q & ~flush_i;

    // ------------------------------------------------
    // Request toward the memory system
    // ------------------------------------------------
    assign mem_req_o.valid = busy_q | start;
    assign mem_req_o.we    = 1'b0;
    assign mem_req_o.addr  = busy_q ? addr_q : pc_q;
    assign mem_req_o.wdata = '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q        <= BOOT_PC;
            busy_q      <= 1'b0;
            discard_q   <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            busy_q <= mem_req_o.valid & ~mem_ans_i.valid;

            if (flush_i) begin
                pc_q      <= redirect_q;
                // Answer still in flight belongs to the wrong path
                discard_q <= busy_q & ~mem_ans_i.valid;
            end else begin
                if (start) begin
                    pc_q <= pc_q + XLEN'(4);
                end
                if (mem_ans_i.valid) begin
                    discard_q <= 1'b0;
                end
            end

            if (flush_i) begin
                buf_valid_q <= 1'b0;
            end else if (fill) begin
                buf_valid_q <= 1'b1;
            end else if (take) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q <= pc_q;
        end
        if (fill) begin
            buf_pc_q    <= addr_q;
            buf_instr_q <= mem_ans_i.rdata;
        end
        // Target is used by the flush in the next cycle
        if (res_i.valid && res_i.taken) begin
            redirect_q <= res_i.target;
        end
    end

    assign fetch_o.valid = buf_valid_q;
    assign fetch_o.pc    = buf_pc_q;
    assign fetch_o.instr = buf_instr_q;

endmodule

//--- rtl/backend.sv
// ------------------------------------------------
// Decode and execute backend
// ------------------------------------------------
`timescale 1ns/1ps

module backend (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  core_pkg::fetch_t      fetch_i,
    output logic                  fetch_ready_o,
    output core_pkg::resolution_t res_o,
    output core_pkg::mem_req_t    mem_req_o,
    input  core_pkg::mem_ans_t    mem_ans_i,
    output logic                  ecall_o,
    output logic                  except_o
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        BE_IDLE,
        BE_EXEC,
        BE_MEM
    } be_state_e;

    be_state_e       state_q;
    instr_u          ir_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rf_q [32];

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] rd_data;
    logic            rd_we;
    logic            exec;
    logic            br_taken;
    logic            is_addi;
    logic            is_add;
    logic            is_sub;
    logic            is_lw;
    logic            is_sw;
    logic            is_beq;
    logic            is_bne;
    logic            is_jal;
    logic            is_ecall;
    logic            illegal;

    assign exec          = (state_q == BE_EXEC);
    assign fetch_ready_o = (state_q == BE_IDLE) & ~stall_i;

    // ------------------------------------------------
    // Decode
    // ------------------------------------------------
    always_comb begin
        is_addi  = 1'b0;
        is_add   = 1'b0;
        is_sub   = 1'b0;
        is_lw    = 1'b0;
        is_sw    = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_jal   = 1'b0;
        is_ecall = 1'b0;
        unique case (ir_q.r.opcode)
            OPC_OP_IMM: is_addi = (ir_q.i.funct3 == F3_ADD);
            OPC_OP: begin
                is_add = (ir_q.r.funct3 == F3_ADD) && (ir_q.r.funct7 == F7_ADD);
                is_sub = (ir_q.r.funct3 == F3_ADD) && (ir_q.r.funct7 == F7_SUB);
            end
            OPC_LOAD:   is_lw = (ir_q.i.funct3 == F3_WORD);
            OPC_STORE:  is_sw = (ir_q.r.funct3 == F3_WORD);
            OPC_BRANCH: begin
                is_beq = (ir_q.r.funct3 == F3_BEQ);
                is_bne = (ir_q.r.funct3 == F3_BNE);
            end
            OPC_JAL:    is_jal = 1'b1;
            // Only the plain ECALL word is accepted
            OPC_SYSTEM: is_ecall = (ir_q.i.imm == '0) && (ir_q.i.rs1 == '0) &&
                                   (ir_q.i.funct3 == '0) && (ir_q.i.rd == '0);
            default: ;
        endcase
    end

    assign illegal = ~(is_addi | is_add | is_sub | is_lw | is_sw |
                       is_beq | is_bne | is_jal | is_ecall);

    // Immediates, S/B/J gathered from the R view
    assign imm_i = {{20{ir_q.i.imm[11]}}, ir_q.i.imm};
    assign imm_s = {{20{ir_q.r.funct7[6]}}, ir_q.r.funct7, ir_q.r.rd};
    assign imm_b = {{19{ir_q.r.funct7[6]}}, ir_q.r.funct7[6], ir_q.r.rd[0],
                    ir_q.r.funct7[5:0], ir_q.r.rd[4:1], 1'b0};
    assign imm_j = {{11{ir_q.r.funct7[6]}}, ir_q.r.funct7[6], ir_q.r.rs1, ir_q.r.funct3,
                    ir_q.r.rs2[0], ir_q.r.funct7[5:0], ir_q.r.rs2[4:1], 1'b0};

    // ------------------------------------------------
    // Register read and ALU
    // ------------------------------------------------
    assign rs1_val = (ir_q.r.rs1 == '0) ? '0 : rf_q[ir_q.r.rs1];
    assign rs2_val = (ir_q.r.rs2 == '0) ? '0 : rf_q[ir_q.r.rs2];

    assign alu_res  = is_sub ? (rs1_val - rs2_val) :
                      is_add ? (rs1_val + rs2_val) : (rs1_val + imm_i);
    assign br_taken = is_beq ? (rs1_val == rs2_val) : (rs1_val != rs2_val);

    // Write-back source
    always_comb begin
        rd_we   = 1'b0;
        rd_data = alu_res;
        if (exec && (is_addi || is_add || is_sub)) begin
            rd_we = 1'b1;
        end else if (exec && is_jal) begin
            rd_we   = 1'b1;
            rd_data = pc_q + XLEN'(4);
        end else if (state_q == BE_MEM && mem_ans_i.valid && is_lw) begin
            rd_we   = 1'b1;
            rd_data = mem_ans_i.rdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_we && ir_q.r.rd != '0) begin
            rf_q[ir_q.r.rd] <= rd_data;
        end
        if (fetch_i.valid && fetch_ready_o) begin
            ir_q <= fetch_i.instr;
            pc_q <= fetch_i.pc;
        end
    end

    // ------------------------------------------------
    // Sequencer
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= BE_IDLE;
        end else begin
            unique case (state_q)
                BE_IDLE: if (fetch_i.valid && fetch_ready_o) state_q <= BE_EXEC;
                BE_EXEC: state_q <= (is_lw || is_sw) ? BE_MEM : BE_IDLE;
                BE_MEM:  if (mem_ans_i.valid) state_q <= BE_IDLE;
                default: state_q <= BE_IDLE;
            endcase
        end
    end

    // Request is held stable by ir_q until the answer
    assign mem_req_o.valid = (state_q == BE_MEM);
    assign mem_req_o.we    = is_sw;
    assign mem_req_o.addr  = rs1_val + (is_sw ? imm_s : imm_i);
    assign mem_req_o.wdata = rs2_val;

    assign res_o.valid  = exec & (is_beq | is_bne | is_jal);
    assign res_o.taken  = is_jal | br_taken;
    assign res_o.target = pc_q + (is_jal ? imm_j : imm_b);

    assign ecall_o  = exec & is_ecall;
    assign except_o = exec & illegal;

endmodule

//--- rtl/memory_system.sv
// ------------------------------------------------
// Arbiter and Wishbone master
// ------------------------------------------------
`timescale 1ns/1ps

module memory_system (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  core_pkg::mem_req_t if_req_i,
    input  core_pkg::mem_req_t ls_req_i,
    output core_pkg::mem_ans_t if_ans_o,
    output core_pkg::mem_ans_t ls_ans_o,
    output core_pkg::wb_req_t  wb_req_o,
    input  core_pkg::wb_rsp_t  wb_rsp_i
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_BUSY,
        MS_RECOVER
    } ms_state_e;

    ms_state_e       state_q;
    logic            grant_ls_q;
    logic            cyc_q;
    logic            we_q;
    logic [XLEN-1:0] adr_q;
    logic [XLEN-1:0] dat_q;
    mem_req_t        pick;
    logic            launch;
    logic            done;

    // Load/store port wins
    assign pick   = ls_req_i.valid ? ls_req_i : if_req_i;
    assign launch = (state_q == MS_IDLE) & (ls_req_i.valid | if_req_i.valid);
    assign done   = (state_q == MS_BUSY) & wb_rsp_i.ack;

    // ------------------------------------------------
    // Bus cycle control
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= MS_IDLE;
            cyc_q      <= 1'b0;
            grant_ls_q <= 1'b0;
        end else begin
            unique case (state_q)
                MS_IDLE: if (launch) begin
                    state_q    <= MS_BUSY;
                    cyc_q      <= 1'b1;
                    grant_ls_q <= ls_req_i.valid;
                end
                MS_BUSY: if (wb_rsp_i.ack) begin
                    state_q <= MS_RECOVER;
                    cyc_q   <= 1'b0;
                end
                // Idle gap between bus cycles
                MS_RECOVER: state_q <= MS_IDLE;
                default:    state_q <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin
            we_q  <= pick.we;
            adr_q <= pick.addr;
            dat_q <= pick.wdata;
        end
    end

    assign wb_req_o.cyc = cyc_q;
    assign wb_req_o.stb = cyc_q;
    assign wb_req_o.we  = we_q;
    assign wb_req_o.adr = adr_q;
    assign wb_req_o.dat = dat_q;
    assign wb_req_o.sel = 4'hF;

    // Answer only to the granted side
    assign ls_ans_o.valid = done & grant_ls_q;
    assign ls_ans_o.rdata = wb_rsp_i.dat;
    assign if_ans_o.valid = done & ~grant_ls_q;
    assign if_ans_o.rdata = wb_rsp_i.dat;

endmodule

//--- rtl/datapath.sv
// ------------------------------------------------
// RV32 core datapath top
// ------------------------------------------------
`timescale 1ns/1ps

module datapath (
    // Clock and reset
    input  logic              clk_i,
    input  logic              rst_n_i,

    // L2 memory port
    output core_pkg::wb_req_t wb_req_o,
    input  core_pkg::wb_rsp_t wb_rsp_i,

    // Status
    output logic              halt_o,
    output logic              except_o
);

    import core_pkg::*;

    // ------------------------------------------------
    // Internal signals
    // ------------------------------------------------

    // Control unit to the pipe
    logic        cu_flush;
    logic        cu_stall;

    // Backend to control unit
    logic        be_cu_ecall;
    logic        be_cu_except;
    resolution_t be_res;

    // Frontend to backend
    fetch_t      fe_be_fetch;
    logic        be_fe_ready;

    // Requesters to memory system
    mem_req_t    fe_mem_req;
    mem_ans_t    mem_fe_ans;
    mem_req_t    be_mem_req;
    mem_ans_t    mem_be_ans;

    // ------------------------------------------------
    // Main control unit
    // ------------------------------------------------
    main_cu u_main_cu (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .res_i    (be_res),
        .ecall_i  (be_cu_ecall),
        .except_i (be_cu_except),
        .flush_o  (cu_flush),
        .stall_o  (cu_stall),
        .halt_o   (halt_o),
        .except_o (except_o)
    );

    // ------------------------------------------------
    // Frontend and backend
    // ------------------------------------------------
    frontend u_frontend (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (cu_flush),
        .stall_i       (cu_stall),
        .res_i         (be_res),
        .mem_req_o     (fe_mem_req),
        .mem_ans_i     (mem_fe_ans),
        .fetch_o       (fe_be_fetch),
        .fetch_ready_i (be_fe_ready)
    );

    backend u_backend (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (cu_stall),
        .fetch_i       (fe_be_fetch),
        .fetch_ready_o (be_fe_ready),
        .res_o         (be_res),
        .mem_req_o     (be_mem_req),
        .mem_ans_i     (mem_be_ans),
        .ecall_o       (be_cu_ecall),
        .except_o      (be_cu_except)
    );

    // ------------------------------------------------
    // Memory system
    // ------------------------------------------------
    memory_system u_memory_system (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .if_req_i (fe_mem_req),
        .ls_req_i (be_mem_req),
        .if_ans_o (mem_fe_ans),
        .ls_ans_o (mem_be_ans),
        .wb_req_o (wb_req_o),
        .wb_rsp_i (wb_rsp_i)
    );

endmodule

//--- verif/datapath_props.sv
// ------------------------------------------------
// Wishbone master properties
// ------------------------------------------------
`timescale 1ns/1ps

module datapath_props (
    input logic              clk_i,
    input logic              rst_n_i,
    input core_pkg::wb_req_t wb_req_i,
    input core_pkg::wb_rsp_t wb_rsp_i
);

    // Strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_req_i.stb |-> wb_req_i.cyc)
        else $error("wb stb high without cyc");

    // Request held until the slave acks
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_req_i.stb && !wb_rsp_i.ack) |=>
            (wb_req_i.stb && $stable(wb_req_i.adr) && $stable(wb_req_i.we) &&
             $stable(wb_req_i.dat)))
        else $error("wb request changed before ack");

    // Idle cycle after every ack
    cyc_drop: assert property (@(posedge clk_i)
        wb_rsp_i.ack |=> !wb_req_i.cyc)
        else $error("wb cyc still high after ack");

    no_stb_in_reset: assert property (@(posedge clk_i)
        $past(!rst_n_i) |-> !wb_req_i.stb)
        else $error("wb stb high during reset");

endmodule

bind memory_system datapath_props u_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_req_i (wb_req_o),
    .wb_rsp_i (wb_rsp_i)
);

//--- verif/tb_datapath.sv
// ------------------------------------------------
// RV32 datapath testbench
// ------------------------------------------------
`timescale 1ns/1ps

module tb_datapath;

    import core_pkg::*;

    localparam int HALT_TIMEOUT = 2000;

    // One program with a single result word to check
    typedef struct packed {
        logic [11:0][ILEN-1:0] prog;
        logic [XLEN-1:0]       res_addr;
        logic [XLEN-1:0]       exp_word;
        logic                  exp_exc;
    } test_t;

    logic            clk = 1'b0;
    logic            rst_n = 1'b0;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp = '0;
    logic            halt;
    logic            exc;

    // L2 memory model state
    logic [XLEN-1:0] mem [256];
    integer          seed = 63942;
    int              ack_delay = 0;
    logic            in_cycle = 1'b0;

    test_t           tests [$];
    string           names [$];
    logic [ILEN-1:0] pq [$];
    int              check_errors = 0;
    int              passed = 0;
    int              failed = 0;

    always #4 clk = ~clk;

    datapath i_dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_req_o (wb_req),
        .wb_rsp_i (wb_rsp),
        .halt_o   (halt),
        .except_o (exc)
    );

    // ------------------------------------------------
    // Wishbone slave with random ack delay
    // ------------------------------------------------
    always @(negedge clk) begin
        if (wb_rsp.ack) begin
            // Ack lasts one cycle
            wb_rsp.ack = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!in_cycle) begin
                in_cycle  = 1'b1;
                ack_delay = $random(seed) & 3;
            end
            if (ack_delay == 0) begin
                assert (wb_req.sel == 4'hF) else begin
                    $display("Error at %0d ns: wb_req.sel = %h, expected %h", $time,
                             wb_req.sel, 4'hF);
                    check_errors++;
                end
                if (wb_req.we) begin
                    mem[wb_req.adr[9:2]] = wb_req.dat;
                end
                wb_rsp.dat = mem[wb_req.adr[9:2]];
                wb_rsp.ack = 1'b1;
                in_cycle   = 1'b0;
            end else begin
                ack_delay--;
            end
        end else begin
            // No bus cycle, also covers a cycle cut by reset
            in_cycle = 1'b0;
        end
    end

    // ------------------------------------------------
    // RV32I encodings of the used subset
    // ------------------------------------------------
    function automatic logic [ILEN-1:0] addi(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic logic [ILEN-1:0] add(int rd, int rs1, int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [ILEN-1:0] sub(int rd, int rs1, int rs2);
        return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [ILEN-1:0] lw(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
    endfunction

    function automatic logic [ILEN-1:0] sw(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [ILEN-1:0] beq(int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [ILEN-1:0] bne(int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b001, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [ILEN-1:0] jal(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic [ILEN-1:0] ecall();
        return {25'd0, OPC_SYSTEM};
    endfunction

    // Table entry from the program collected in pq
    task automatic add_test(input string name, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] word, input logic exp_exc);
        test_t t;
        t = '0;
        for (int k = 0; k < pq.size() && k < 12; k++) begin
            t.prog[k[3:0]] = pq[k];
        end
        t.res_addr = addr;
        t.exp_word = word;
        t.exp_exc  = exp_exc;
        tests.push_back(t);
        names.push_back(name);
    endtask

    // ------------------------------------------------
    // Program table
    // ------------------------------------------------
    task automatic build_tests();
        pq.delete();
        pq.push_back(addi(1, 0, 1234));
        pq.push_back(addi(2, 0, -2000));
        pq.push_back(add(3, 1, 2));
        pq.push_back(sw(3, 0, 'h200));
        pq.push_back(ecall());
        add_test("addi_add_sw", 32'h200, 32'(1234 - 2000), 1'b0);

        // x0 write must be dropped
        pq.delete();
        pq.push_back(addi(1, 0, 100));
        pq.push_back(addi(0, 0, 55));
        pq.push_back(addi(2, 0, 300));
        pq.push_back(sub(3, 1, 2));
        pq.push_back(add(3, 3, 0));
        pq.push_back(sw(3, 0, 'h204));
        pq.push_back(ecall());
        add_test("sub_x0", 32'h204, 32'(100 - 300), 1'b0);

        pq.delete();
        pq.push_back(addi(1, 0, 1445));
        pq.push_back(sw(1, 0, 'h208));
        pq.push_back(lw(2, 0, 'h208));
        pq.push_back(addi(3, 0, 77));
        pq.push_back(add(4, 2, 3));
        pq.push_back(sw(4, 0, 'h20C));
        pq.push_back(ecall());
        add_test("sw_lw_add_sw", 32'h20C, 32'(1445 + 77), 1'b0);

        // Taken branch skips the marker store
        pq.delete();
        pq.push_back(addi(1, 0, 9));
        pq.push_back(addi(2, 0, 9));
        pq.push_back(addi(5, 0, 60));
        pq.push_back(beq(1, 2, 8));
        pq.push_back(sw(5, 0, 'h210));
        pq.push_back(sw(1, 0, 'h214));
        pq.push_back(ecall());
        add_test("beq_skip_marker", 32'h210, 32'd0, 1'b0);
        add_test("beq_target", 32'h214, 32'd9, 1'b0);

        // Countdown 5..1, then JAL over two words
        pq.delete();
        pq.push_back(addi(1, 0, 5));
        pq.push_back(addi(2, 0, 0));
        pq.push_back(add(2, 2, 1));
        pq.push_back(addi(1, 1, -1));
        pq.push_back(bne(1, 0, -8));
        pq.push_back(sw(2, 0, 'h218));
        pq.push_back(jal(6, 12));
        pq.push_back(sw(2, 0, 'h21C));
        pq.push_back(ecall());
        pq.push_back(sw(6, 0, 'h220));
        pq.push_back(ecall());
        add_test("bne_loop_sum", 32'h218, 32'(5 + 4 + 3 + 2 + 1), 1'b0);
        add_test("jal_link", 32'h220, BOOT_PC + 32'd24 + 32'd4, 1'b0);

        pq.delete();
        pq.push_back(addi(1, 0, 42));
        pq.push_back(sw(1, 0, 'h224));
        pq.push_back(32'hFFFF_FFFF);
        pq.push_back(sw(1, 0, 'h228));
        pq.push_back(ecall());
        add_test("illegal_after_sw", 32'h224, 32'd42, 1'b1);
        add_test("illegal_no_store", 32'h228, 32'd0, 1'b1);
    endtask

    // ------------------------------------------------
    // Run one table entry
    // ------------------------------------------------
    task automatic run_test(input int idx);
        int              cycles;
        int              errors_before;
        logic [XLEN-1:0] got;

        errors_before = check_errors;

        // Memory reloaded while the core is in reset
        rst_n = 1'b0;
        @(negedge clk);
        for (int a = 0; a < 256; a++) begin
            mem[a[7:0]] = '0;
        end
        for (int k = 0; k < 12; k++) begin
            mem[BOOT_PC[9:2] + k[7:0]] = tests[idx].prog[k[3:0]];
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        cycles = 0;
        while (!halt && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end

        if (!halt) begin
            $display("Timeout in test %0d: halt_o still low after %0d cycles", idx, cycles);
            check_errors++;
        end else begin
            got = mem[tests[idx].res_addr[9:2]];
            assert (got == tests[idx].exp_word) else begin
                $display("Error at %0d ns: mem[%h] = %h, expected %h", $time,
                         tests[idx].res_addr, got, tests[idx].exp_word);
                check_errors++;
            end
            assert (exc == tests[idx].exp_exc) else begin
                $display("Error at %0d ns: except_o = %b, expected %b", $time,
                         exc, tests[idx].exp_exc);
                check_errors++;
            end
        end

        if (check_errors == errors_before) begin
            passed++;
            $display("test %0d %s: ok", idx, names[idx]);
        end else begin
            failed++;
            $display("test %0d %s: failed", idx, names[idx]);
        end
    endtask

    initial begin
        build_tests();
        @(negedge clk);
        for (int n = 0; n < tests.size(); n++) begin
            run_test(n);
        end
        $display("%0d tests: %0d passed, %0d failed", tests.size(), passed, failed);
        if (failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/core_pkg.sv
rtl/main_cu.sv
rtl/frontend.sv
rtl/backend.sv
rtl/memory_system.sv
rtl/datapath.sv
verif/datapath_props.sv
verif/tb_datapath.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_datapath
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TEST PASS

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
